// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -j 0
TOP       := mem_bridge_tb
FILELIST  := mem_bridge.f
OBJ_DIR   := obj_dir
SIM_BIN   := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log
SRCS      := $(shell cat $(FILELIST))

.PHONY: all run check clean

all: check

# rebuilt only when a source or the file list changes
$(SIM_BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: $(SIM_BIN)
	./$(SIM_BIN) +verilator+error+limit+100 > $(LOG) 2>&1; cat $(LOG)

check: run
	@if grep -q "ERRORS FOUND" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "NO ERRORS" $(LOG) || (echo "simulation ended without a result"; exit 1)
	@echo "simulation passed"

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: dv/axi_mem_model.sv
`timescale 1ns/1ps

module axi_mem_model (
    input  logic        i_clk,
    input  logic        i_rst,
    input  logic [3:0]  i_arid,
    input  logic [31:0] i_araddr,
    input  logic        i_arvalid,
    output logic        o_arready,
    output logic [3:0]  o_rid,
    output logic [31:0] o_rdata,
    output logic        o_rlast,
    output logic        o_rvalid,
    input  logic        i_rready,
    input  logic [31:0] i_awaddr,
    input  logic        i_awvalid,
    output logic        o_awready,
    input  logic [31:0] i_wdata,
    input  logic        i_wlast,
    input  logic        i_wvalid,
    output logic        o_wready,
    output logic        o_bvalid,
    input  logic        i_bready
);

    int seed = 32'hb4be_a7e1;
    logic [31:0] mem [256];

    // accepted read bursts, id above address
    logic [35:0] ar_q [$];
    logic        r_act;
    logic [3:0]  r_id;
    logic [7:0]  r_idx;
    logic [1:0]  r_beat;

    // write burst in progress
    logic        w_act;
    logic [7:0]  w_idx;

    // random ready stalls, low about one cycle in four
    logic        ar_ok;
    logic        aw_ok;
    logic        w_ok;

    assign o_arready = ar_ok;
    // one write at a time, aw then w then b
    assign o_awready = aw_ok & ~w_act & ~o_bvalid;
    assign o_wready = w_ok & w_act;

    // read beats in order, no stalls on rvalid
    assign o_rvalid = r_act;
    assign o_rid = r_id;
    assign o_rdata = mem[r_idx];
    assign o_rlast = r_act & (r_beat == 2'd3);

    always @(posedge i_clk) begin
        ar_ok <= ($random(seed) & 3) != 0;
        aw_ok <= ($random(seed) & 3) != 0;
        w_ok <= ($random(seed) & 3) != 0;
        if (i_rst) begin
            // initial contents: word index xor fixed pattern
            for (int i = 0; i < 256; i++) begin
                mem[i] <= 32'(i) ^ 32'h5a5a_0000;
            end
            ar_q.delete();
            r_act <= 1'b0;
            r_beat <= 2'd0;
            w_act <= 1'b0;
            o_bvalid <= 1'b0;
        end else begin
            if (i_arvalid && o_arready) begin
                ar_q.push_back({i_arid, i_araddr});
            end
            if (r_act && i_rready) begin
                r_idx <= r_idx + 8'd1;
                r_beat <= r_beat + 2'd1;
                r_act <= (r_beat != 2'd3);
            end else if (!r_act && ar_q.size() != 0) begin
                // next queued burst, word index wraps in 256 words
                r_id <= ar_q[0][35:32];
                r_idx <= ar_q[0][9:2];
                void'(ar_q.pop_front());
                r_beat <= 2'd0;
                r_act <= 1'b1;
            end
            if (i_awvalid && o_awready) begin
                w_act <= 1'b1;
                w_idx <= i_awaddr[9:2];
            end
            if (i_wvalid && o_wready) begin
                mem[w_idx] <= i_wdata;
                w_idx <= w_idx + 8'd1;
                if (i_wlast) begin
                    w_act <= 1'b0;
                    o_bvalid <= 1'b1;
                end
            end
            if (o_bvalid && i_bready) begin
                o_bvalid <= 1'b0;
            end
        end
    end

endmodule

// File: dv/mem_bridge_chk.sv
`timescale 1ns/1ps

module mem_bridge_chk (
    input logic        i_clk,
    input logic        i_rst,
    input logic        i_if_done,
    input logic        i_dl_done,
    input logic        i_if_ready,
    input logic        i_dl_ready,
    input logic        i_arvalid,
    input logic        i_arready,
    input logic [31:0] i_araddr,
    input logic [3:0]  i_arid,
    input logic [3:0]  i_arlen,
    input logic [2:0]  i_arsize,
    input logic [1:0]  i_arburst,
    input logic [1:0]  i_arlock,
    input logic [3:0]  i_arcache,
    input logic [2:0]  i_arprot,
    input logic        i_awvalid,
    input logic        i_awready,
    input logic [31:0] i_awaddr,
    input logic [3:0]  i_awid,
    input logic [3:0]  i_awlen,
    input logic [2:0]  i_awsize,
    input logic [1:0]  i_awburst,
    input logic [1:0]  i_awlock,
    input logic [3:0]  i_awcache,
    input logic [2:0]  i_awprot,
    input logic        i_wvalid,
    input logic        i_wready,
    input logic        i_wlast,
    input logic [3:0]  i_wid,
    input logic [3:0]  i_wstrb
);

    // read by the testbench top
    int fail_cnt = 0;

    // w beats already taken in the current burst
    logic [2:0] wbeats;

    always @(posedge i_clk) begin
        if (i_rst) begin
            wbeats <= 3'd0;
        end else if (i_wvalid && i_wready) begin
            wbeats <= i_wlast ? 3'd0 : wbeats + 3'd1;
        end
    end

    // state one cycle after any reset cycle
    reset_idle: assert property (@(posedge i_clk) i_rst |=>
        (!i_if_done && !i_dl_done && !i_arvalid && !i_awvalid && !i_wvalid
         && i_if_ready && i_dl_ready))
    else begin
        $error("done, valid or ready outputs wrong after reset");
        fail_cnt++;
    end

    // read address held under a stall
    ar_stable: assert property (@(posedge i_clk) disable iff (i_rst)
        (i_arvalid && !i_arready) |=> (i_arvalid && $stable(i_araddr) && $stable(i_arid)))
    else begin
        $error("read address channel changed before arready");
        fail_cnt++;
    end

    // write address held under a stall
    aw_stable: assert property (@(posedge i_clk) disable iff (i_rst)
        (i_awvalid && !i_awready) |=> (i_awvalid && $stable(i_awaddr)))
    else begin
        $error("write address channel changed before awready");
        fail_cnt++;
    end

    // one line of 32-bit incr beats, len is words minus one
    ar_attr: assert property (@(posedge i_clk) disable iff (i_rst)
        i_arvalid |-> ({i_arlen, i_arsize, i_arburst, i_arlock, i_arcache, i_arprot}
            == {4'(mem_bridge_pkg::LINE_WORDS - 1), 3'b010, 2'b01, 2'b00, 4'h0, 3'h0}))
    else begin
        $error("ERROR t=%0t o_arlen..o_arprot got %h expected %h", $time,
               $sampled({i_arlen, i_arsize, i_arburst, i_arlock, i_arcache, i_arprot}),
               {4'(mem_bridge_pkg::LINE_WORDS - 1), 3'b010, 2'b01, 2'b00, 4'h0, 3'h0});
        fail_cnt++;
    end

    // write bursts carry the data side id 1
    aw_attr: assert property (@(posedge i_clk) disable iff (i_rst)
        i_awvalid |-> ({i_awid, i_awlen, i_awsize, i_awburst, i_awlock, i_awcache, i_awprot}
            == {4'd1, 4'(mem_bridge_pkg::LINE_WORDS - 1), 3'b010, 2'b01, 2'b00, 4'h0, 3'h0}))
    else begin
        $error("ERROR t=%0t o_awid..o_awprot got %h expected %h", $time,
               $sampled({i_awid, i_awlen, i_awsize, i_awburst, i_awlock, i_awcache,
                         i_awprot}),
               {4'd1, 4'(mem_bridge_pkg::LINE_WORDS - 1), 3'b010, 2'b01, 2'b00, 4'h0, 3'h0});
        fail_cnt++;
    end

    // full-word beats only
    w_attr: assert property (@(posedge i_clk) disable iff (i_rst)
        i_wvalid |-> ({i_wid, i_wstrb} == {4'd1, 4'hf}))
    else begin
        $error("ERROR t=%0t o_wid,o_wstrb got %h expected %h", $time,
               $sampled({i_wid, i_wstrb}), {4'd1, 4'hf});
        fail_cnt++;
    end

    // wlast only on beat four
    wlast_pos: assert property (@(posedge i_clk) disable iff (i_rst)
        (i_wvalid && i_wready) |-> (i_wlast == (wbeats == 3'd3)))
    else begin
        $error("wlast not on the fourth write beat");
        fail_cnt++;
    end

endmodule

bind mem_bridge mem_bridge_chk chk_i (
    .i_clk      (i_clk),
    .i_rst      (i_rst),
    .i_if_done  (o_if_done),
    .i_dl_done  (o_dl_done),
    .i_if_ready (o_if_ready),
    .i_dl_ready (o_dl_ready),
    .i_arvalid  (o_arvalid),
    .i_arready  (i_arready),
    .i_araddr   (o_araddr),
    .i_arid     (o_arid),
    .i_arlen    (o_arlen),
    .i_arsize   (o_arsize),
    .i_arburst  (o_arburst),
    .i_arlock   (o_arlock),
    .i_arcache  (o_arcache),
    .i_arprot   (o_arprot),
    .i_awvalid  (o_awvalid),
    .i_awready  (i_awready),
    .i_awaddr   (o_awaddr),
    .i_awid     (o_awid),
    .i_awlen    (o_awlen),
    .i_awsize   (o_awsize),
    .i_awburst  (o_awburst),
    .i_awlock   (o_awlock),
    .i_awcache  (o_awcache),
    .i_awprot   (o_awprot),
    .i_wvalid   (o_wvalid),
    .i_wready   (i_wready),
    .i_wlast    (o_wlast),
    .i_wid      (o_wid),
    .i_wstrb    (o_wstrb)
);

// File: dv/mem_bridge_tb.sv
`timescale 1ns/1ps

module mem_bridge_tb;

    // cycles allowed for any single wait
    localparam int TIMEOUT = 200;

    logic                  i_clk = 1'b0;
    logic                  i_rst;
    logic                  i_if_valid;
    logic                  i_dl_valid;
    logic                  i_dl_write;
    logic [31:0]           i_if_addr;
    logic [31:0]           i_dl_addr;
    mem_bridge_pkg::line_t i_dl_wline;
    mem_bridge_pkg::line_t o_if_line;
    mem_bridge_pkg::line_t o_dl_rline;
    logic                  o_if_ready;
    logic                  o_if_done;
    logic                  o_dl_ready;
    logic                  o_dl_done;
    logic [3:0]            o_arid;
    logic [3:0]            o_arlen;
    logic [3:0]            o_arcache;
    logic [3:0]            o_awid;
    logic [3:0]            o_awlen;
    logic [3:0]            o_awcache;
    logic [3:0]            o_wid;
    logic [3:0]            o_wstrb;
    logic [3:0]            i_rid;
    logic [31:0]           o_araddr;
    logic [31:0]           o_awaddr;
    logic [31:0]           o_wdata;
    logic [31:0]           i_rdata;
    logic [2:0]            o_arsize;
    logic [2:0]            o_arprot;
    logic [2:0]            o_awsize;
    logic [2:0]            o_awprot;
    logic [1:0]            o_arburst;
    logic [1:0]            o_arlock;
    logic [1:0]            o_awburst;
    logic [1:0]            o_awlock;
    logic                  o_arvalid;
    logic                  i_arready;
    logic                  i_rlast;
    logic                  i_rvalid;
    logic                  o_rready;
    logic                  o_awvalid;
    logic                  i_awready;
    logic                  o_wlast;
    logic                  o_wvalid;
    logic                  i_wready;
    logic                  i_bvalid;
    logic                  o_bready;

    int seed = 32'hb4be_a7e1;
    int err_cnt = 0;
    int tests = 0;
    // expected memory, same start rule as the slave
    logic [31:0] ref_mem [256];
    // arid of every read address handshake
    logic [3:0] ar_ids [$];

    always #50 i_clk = ~i_clk;

    mem_bridge mem_bridge_i (.*);

    axi_mem_model axi_mem_model_i (
        .i_clk     (i_clk),
        .i_rst     (i_rst),
        .i_arid    (o_arid),
        .i_araddr  (o_araddr),
        .i_arvalid (o_arvalid),
        .o_arready (i_arready),
        .o_rid     (i_rid),
        .o_rdata   (i_rdata),
        .o_rlast   (i_rlast),
        .o_rvalid  (i_rvalid),
        .i_rready  (o_rready),
        .i_awaddr  (o_awaddr),
        .i_awvalid (o_awvalid),
        .o_awready (i_awready),
        .i_wdata   (o_wdata),
        .i_wlast   (o_wlast),
        .i_wvalid  (o_wvalid),
        .o_wready  (i_wready),
        .o_bvalid  (i_bvalid),
        .i_bready  (o_bready)
    );

    always @(posedge i_clk) begin
        if (o_arvalid && i_arready) begin
            ar_ids.push_back(o_arid);
        end
    end

    // testbench checks plus bound assertion failures
    function automatic int total_errors();
        return err_cnt + mem_bridge_i.chk_i.fail_cnt;
    endfunction

    task automatic check_line(input string name, input mem_bridge_pkg::line_t got,
                              input logic [31:0] addr);
        logic [7:0] idx;
        for (int k = 0; k < mem_bridge_pkg::LINE_WORDS; k++) begin
            // words of the aligned line
            idx = {addr[9:4], 2'b00} + 8'(k);
            assert (got[k] == ref_mem[idx]) else begin
                $display("ERROR t=%0t %s[%0d] got %h expected %h",
                         $time, name, k, got[k], ref_mem[idx]);
                err_cnt++;
            end
        end
    endtask

    task automatic expect_id(input logic [3:0] exp);
        if (ar_ids.size() == 0) begin
            $display("no read address handshake was seen before %0t", $time);
            err_cnt++;
        end else begin
            assert (ar_ids[0] == exp) else begin
                $display("ERROR t=%0t o_arid got %0d expected %0d", $time, ar_ids[0], exp);
                err_cnt++;
            end
        end
    endtask

    // both engines idle so the next requests land on the same edge
    task automatic wait_idle();
        int t;
        for (t = 0; t < TIMEOUT && !(o_if_ready && o_dl_ready); t++) begin
            @(negedge i_clk);
        end
        if (!(o_if_ready && o_dl_ready)) begin
            $display("timeout: cache ports did not both become ready by %0t", $time);
            err_cnt++;
        end
    endtask

    task automatic do_fetch(input logic [31:0] addr);
        int t;
        for (t = 0; t < TIMEOUT && !o_if_ready; t++) begin
            @(negedge i_clk);
        end
        if (!o_if_ready) begin
            $display("timeout: instruction cache port never became ready for %h", addr);
            err_cnt++;
            return;
        end
        i_if_valid = 1'b1;
        i_if_addr = addr;
        @(negedge i_clk);
        i_if_valid = 1'b0;
        for (t = 0; t < TIMEOUT && !o_if_done; t++) begin
            @(negedge i_clk);
        end
        if (!o_if_done) begin
            $display("timeout: instruction fetch of %h never finished", addr);
            err_cnt++;
        end else begin
            check_line("o_if_line", o_if_line, addr);
        end
    endtask

    task automatic do_data(input logic write, input logic [31:0] addr,
                           input mem_bridge_pkg::line_t line);
        int t;
        for (t = 0; t < TIMEOUT && !o_dl_ready; t++) begin
            @(negedge i_clk);
        end
        if (!o_dl_ready) begin
            $display("timeout: data cache port never became ready for %h", addr);
            err_cnt++;
            return;
        end
        i_dl_valid = 1'b1;
        i_dl_write = write;
        i_dl_addr = addr;
        i_dl_wline = line;
        @(negedge i_clk);
        i_dl_valid = 1'b0;
        for (t = 0; t < TIMEOUT && !o_dl_done; t++) begin
            @(negedge i_clk);
        end
        if (!o_dl_done) begin
            $display("timeout: data cache request at %h never finished", addr);
            err_cnt++;
        end else if (write) begin
            // slave now holds the written line
            for (int k = 0; k < mem_bridge_pkg::LINE_WORDS; k++) begin
                ref_mem[{addr[9:4], 2'b00} + 8'(k)] = line[k];
            end
        end else begin
            check_line("o_dl_rline", o_dl_rline, addr);
        end
    endtask

    task automatic report(input string name, input int base);
        tests++;
        $display("test %-16s %s", name, (total_errors() == base) ? "ok" : "failed");
    endtask

    initial begin
        int base;
        logic [31:0] a;
        logic [31:0] b;
        mem_bridge_pkg::line_t wl;
        i_rst = 1'b1;
        i_if_valid = 1'b0;
        i_if_addr = '0;
        i_dl_valid = 1'b0;
        i_dl_write = 1'b0;
        i_dl_addr = '0;
        i_dl_wline = '0;
        for (int i = 0; i < 256; i++) begin
            ref_mem[i] = 32'(i) ^ 32'h5a5a_0000;
        end

        // idle state checked by reset_idle on every reset edge
        base = total_errors();
        repeat (8) @(negedge i_clk);
        i_rst = 1'b0;
        @(negedge i_clk);
        report("reset_state", base);

        base = total_errors();
        for (int n = 0; n < 3; n++) begin
            ar_ids.delete();
            a = $random(seed);
            do_fetch(a);
            expect_id(mem_bridge_pkg::ID_IFETCH);
        end
        report("ifetch_read", base);

        base = total_errors();
        for (int n = 0; n < 3; n++) begin
            ar_ids.delete();
            a = $random(seed);
            do_data(1'b0, a, '0);
            expect_id(mem_bridge_pkg::ID_DATA);
        end
        report("data_read", base);

        // write back a random line, then read it again
        base = total_errors();
        a = $random(seed);
        for (int k = 0; k < mem_bridge_pkg::LINE_WORDS; k++) begin
            wl[k] = $random(seed);
        end
        do_data(1'b1, a, wl);
        do_data(1'b0, a, '0);
        report("write_readback", base);

        // both caches accepted on the same edge
        base = total_errors();
        wait_idle();
        ar_ids.delete();
        a = $random(seed);
        b = $random(seed);
        fork
            do_fetch(a);
            do_data(1'b0, b, '0);
        join
        expect_id(mem_bridge_pkg::ID_IFETCH);
        report("both_same_cycle", base);

        // mixed traffic for the stall assertions
        base = total_errors();
        for (int n = 0; n < 6; n++) begin
            a = $random(seed);
            for (int k = 0; k < mem_bridge_pkg::LINE_WORDS; k++) begin
                wl[k] = $random(seed);
            end
            fork
                do_fetch(a ^ 32'h0000_0100);
                do_data(n[0], a, wl);
            join
        end
        report("random_stalls", base);

        $display("%0d tests run, %0d errors", tests, total_errors());
        if (total_errors() == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

// File: logic/axi_port_arbiter.sv
`timescale 1ns/1ps

module axi_port_arbiter (
    input  logic        i_clk,
    input  logic        i_rst,
    rd_bus_if.arbiter   irq_rd,
    rd_bus_if.arbiter   drq_rd,
    wr_bus_if.arbiter   drq_wr,
    // read address
    output logic [3:0]  o_arid,
    output logic [31:0] o_araddr,
    output logic [3:0]  o_arlen,
    output logic [2:0]  o_arsize,
    output logic [1:0]  o_arburst,
    output logic [1:0]  o_arlock,
    output logic [3:0]  o_arcache,
    output logic [2:0]  o_arprot,
    output logic        o_arvalid,
    input  logic        i_arready,
    // read data
    input  logic [3:0]  i_rid,
    input  logic [31:0] i_rdata,
    input  logic        i_rlast,
    input  logic        i_rvalid,
    output logic        o_rready,
    // write address
    output logic [3:0]  o_awid,
    output logic [31:0] o_awaddr,
    output logic [3:0]  o_awlen,
    output logic [2:0]  o_awsize,
    output logic [1:0]  o_awburst,
    output logic [1:0]  o_awlock,
    output logic [3:0]  o_awcache,
    output logic [2:0]  o_awprot,
    output logic        o_awvalid,
    input  logic        i_awready,
    // write data
    output logic [3:0]  o_wid,
    output logic [31:0] o_wdata,
    output logic [3:0]  o_wstrb,
    output logic        o_wlast,
    output logic        o_wvalid,
    input  logic        i_wready,
    // write response
    input  logic        i_bvalid,
    output logic        o_bready
);

    // grant held from choice until the ar handshake
    logic gnt_valid_q;
    // 0 instruction side, 1 data side
    logic gnt_dat_q;
    // read data owner from the id
    logic r_sel;

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            gnt_valid_q <= 1'b0;
            gnt_dat_q <= 1'b0;
        end else if (!gnt_valid_q) begin
            // instruction side first
            if (irq_rd.req_valid) begin
                gnt_valid_q <= 1'b1;
                gnt_dat_q <= 1'b0;
            end else if (drq_rd.req_valid) begin
                gnt_valid_q <= 1'b1;
                gnt_dat_q <= 1'b1;
            end
        end else if (o_arvalid && i_arready) begin
            gnt_valid_q <= 1'b0;
        end
    end

    // ar channel driven from the locked grant
    assign o_arvalid = gnt_valid_q & (gnt_dat_q ? drq_rd.req_valid : irq_rd.req_valid);
    assign o_araddr = gnt_dat_q ? drq_rd.req_addr : irq_rd.req_addr;
    assign o_arid = gnt_dat_q ? mem_bridge_pkg::ID_DATA : mem_bridge_pkg::ID_IFETCH;
    assign o_arlen = mem_bridge_pkg::BURST_LEN;
    assign o_arsize = mem_bridge_pkg::WORD_SIZE;
    assign o_arburst = mem_bridge_pkg::BURST_INCR;
    assign o_arlock = 2'd0;
    assign o_arcache = 4'd0;
    assign o_arprot = 3'd0;
    assign irq_rd.req_ready = gnt_valid_q & ~gnt_dat_q & i_arready;
    assign drq_rd.req_ready = gnt_valid_q & gnt_dat_q & i_arready;

    // r beats steered by id bit 0
    assign r_sel = i_rid[0];
    assign irq_rd.rdata = i_rdata;
    assign irq_rd.rlast = ~r_sel & i_rlast;
    assign irq_rd.rvalid = ~r_sel & i_rvalid;
    assign drq_rd.rdata = i_rdata;
    assign drq_rd.rlast = r_sel & i_rlast;
    assign drq_rd.rvalid = r_sel & i_rvalid;
    assign o_rready = r_sel ? drq_rd.rready : irq_rd.rready;

    // write channels belong to the data side
    assign o_awid = mem_bridge_pkg::ID_DATA;
    assign o_awaddr = drq_wr.awaddr;
    assign o_awlen = mem_bridge_pkg::BURST_LEN;
    assign o_awsize = mem_bridge_pkg::WORD_SIZE;
    assign o_awburst = mem_bridge_pkg::BURST_INCR;
    assign o_awlock = 2'd0;
    assign o_awcache = 4'd0;
    assign o_awprot = 3'd0;
    assign o_awvalid = drq_wr.awvalid;
    assign drq_wr.awready = i_awready;

    // full words only
    assign o_wid = mem_bridge_pkg::ID_DATA;
    assign o_wdata = drq_wr.wdata;
    assign o_wstrb = 4'hf;
    assign o_wlast = drq_wr.wlast;
    assign o_wvalid = drq_wr.wvalid;
    assign drq_wr.wready = i_wready;

    assign drq_wr.bvalid = i_bvalid;
    assign o_bready = drq_wr.bready;

endmodule

// File: logic/dline_mover.sv
`timescale 1ns/1ps

module dline_mover (
    input  logic                  i_clk,
    input  logic                  i_rst,
    input  logic                  i_valid,
    input  logic                  i_write,
    input  mem_bridge_pkg::addr_u i_addr,
    input  mem_bridge_pkg::line_t i_wline,
    output logic                  o_ready,
    output mem_bridge_pkg::line_t o_rline,
    output logic                  o_done,
    rd_bus_if.engine              rd,
    wr_bus_if.engine              wr
);

    // one-hot state, idle when no flag is set
    // read path
    logic st_ar;
    logic st_rd;
    // write path
    logic st_aw;
    logic st_w;
    logic st_b;
    // done pulse
    logic done_q;

    // aligned address, word field counts beats in both directions
    mem_bridge_pkg::addr_u addr_q;
    // read fill target, or captured write-back line
    mem_bridge_pkg::line_t line_q;

    logic accept;
    logic rbeat;
    logic wbeat;
    logic last_word;

    assign o_ready = ~(st_ar | st_rd | st_aw | st_w | st_b | done_q);
    assign accept = i_valid & o_ready;
    assign rbeat = st_rd & rd.rvalid;
    assign wbeat = st_w & wr.wready;
    assign last_word = ({2'b00, addr_q.f.word} == mem_bridge_pkg::BURST_LEN);

    // read channel
    assign rd.req_valid = st_ar;
    assign rd.req_addr = addr_q.raw;
    assign rd.rready = st_rd;

    // write channel, beats follow the aw handshake
    assign wr.awvalid = st_aw;
    assign wr.awaddr = addr_q.raw;
    assign wr.wvalid = st_w;
    assign wr.wdata = line_q[addr_q.f.word];
    assign wr.wlast = st_w & last_word;
    assign wr.bready = st_b;

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            st_ar <= 1'b0;
            st_rd <= 1'b0;
            st_aw <= 1'b0;
            st_w <= 1'b0;
            st_b <= 1'b0;
            done_q <= 1'b0;
        end else begin
            done_q <= 1'b0;
            if (accept) begin
                st_aw <= i_write;
                st_ar <= ~i_write;
            end
            // read: address then four beats
            if (st_ar && rd.req_ready) begin
                st_ar <= 1'b0;
                st_rd <= 1'b1;
            end
            if (rbeat && rd.rlast) begin
                st_rd <= 1'b0;
                done_q <= 1'b1;
            end
            // write: address, four beats, then response
            if (st_aw && wr.awready) begin
                st_aw <= 1'b0;
                st_w <= 1'b1;
            end
            if (wbeat && last_word) begin
                st_w <= 1'b0;
                st_b <= 1'b1;
            end
            if (st_b && wr.bvalid) begin
                st_b <= 1'b0;
                done_q <= 1'b1;
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (accept) begin
            addr_q.f.line <= i_addr.f.line;
            addr_q.f.word <= 2'd0;
            addr_q.f.byte_off <= 2'd0;
            // capture dirty line for write-back
            if (i_write) begin
                line_q <= i_wline;
            end
        end else if (rbeat) begin
            line_q[addr_q.f.word] <= rd.rdata;
            addr_q.f.word <= addr_q.f.word + 2'd1;
        end else if (wbeat) begin
            addr_q.f.word <= addr_q.f.word + 2'd1;
        end
    end

    assign o_rline = line_q;
    assign o_done = done_q;

endmodule

// File: logic/ifetch_refill.sv
`timescale 1ns/1ps

module ifetch_refill (
    input  logic                  i_clk,
    input  logic                  i_rst,
    input  logic                  i_valid,
    input  mem_bridge_pkg::addr_u i_addr,
    output logic                  o_ready,
    output mem_bridge_pkg::line_t o_line,
    output logic                  o_done,
    rd_bus_if.engine              rd
);

    // phase flags, all low means idle
    logic ar_pend;
    logic fill;
    logic done_q;

    // aligned line address, word field doubles as beat index
    mem_bridge_pkg::addr_u addr_q;
    mem_bridge_pkg::line_t line_q;

    logic accept;
    logic beat;
    logic fill_end;

    assign o_ready = ~(ar_pend | fill | done_q);
    assign accept = i_valid & o_ready;
    assign beat = fill & rd.rvalid;

    // rlast ends the burst, beat count as a backstop
    assign fill_end = rd.rlast | ({2'b00, addr_q.f.word} == mem_bridge_pkg::BURST_LEN);

    // one request per line, held until the arbiter takes it
    assign rd.req_valid = ar_pend;
    assign rd.req_addr = addr_q.raw;
    assign rd.rready = fill;

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            ar_pend <= 1'b0;
            fill <= 1'b0;
            done_q <= 1'b0;
        end else begin
            // done is a single cycle pulse
            done_q <= 1'b0;
            if (accept) begin
                ar_pend <= 1'b1;
            end
            if (ar_pend && rd.req_ready) begin
                ar_pend <= 1'b0;
                fill <= 1'b1;
            end
            if (beat && fill_end) begin
                fill <= 1'b0;
                done_q <= 1'b1;
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (accept) begin
            // force line alignment
            addr_q.f.line <= i_addr.f.line;
            addr_q.f.word <= 2'd0;
            addr_q.f.byte_off <= 2'd0;
        end else if (beat) begin
            line_q[addr_q.f.word] <= rd.rdata;
            addr_q.f.word <= addr_q.f.word + 2'd1;
        end
    end

    // buffer only moves on beats, so the line holds after done
    assign o_line = line_q;
    assign o_done = done_q;

endmodule

// File: logic/mem_bridge.sv
`timescale 1ns/1ps

module mem_bridge (
    input  logic                  i_clk,
    input  logic                  i_rst,
    // instruction cache
    input  logic                  i_if_valid,
    input  logic [31:0]           i_if_addr,
    output logic                  o_if_ready,
    output mem_bridge_pkg::line_t o_if_line,
    output logic                  o_if_done,
    // data cache
    input  logic                  i_dl_valid,
    input  logic                  i_dl_write,
    input  logic [31:0]           i_dl_addr,
    input  mem_bridge_pkg::line_t i_dl_wline,
    output logic                  o_dl_ready,
    output mem_bridge_pkg::line_t o_dl_rline,
    output logic                  o_dl_done,
    // axi3 read address
    output logic [3:0]            o_arid,
    output logic [31:0]           o_araddr,
    output logic [3:0]            o_arlen,
    output logic [2:0]            o_arsize,
    output logic [1:0]            o_arburst,
    output logic [1:0]            o_arlock,
    output logic [3:0]            o_arcache,
    output logic [2:0]            o_arprot,
    output logic                  o_arvalid,
    input  logic                  i_arready,
    // axi3 read data
    input  logic [3:0]            i_rid,
    input  logic [31:0]           i_rdata,
    input  logic                  i_rlast,
    input  logic                  i_rvalid,
    output logic                  o_rready,
    // axi3 write address
    output logic [3:0]            o_awid,
    output logic [31:0]           o_awaddr,
    output logic [3:0]            o_awlen,
    output logic [2:0]            o_awsize,
    output logic [1:0]            o_awburst,
    output logic [1:0]            o_awlock,
    output logic [3:0]            o_awcache,
    output logic [2:0]            o_awprot,
    output logic                  o_awvalid,
    input  logic                  i_awready,
    // axi3 write data and response
    output logic [3:0]            o_wid,
    output logic [31:0]           o_wdata,
    output logic [3:0]            o_wstrb,
    output logic                  o_wlast,
    output logic                  o_wvalid,
    input  logic                  i_wready,
    input  logic                  i_bvalid,
    output logic                  o_bready
);

    // engine to arbiter links
    rd_bus_if if_rd ();
    rd_bus_if dl_rd ();
    wr_bus_if dl_wr ();

    ifetch_refill ifetch_refill_i (
        .i_clk   (i_clk),
        .i_rst   (i_rst),
        .i_valid (i_if_valid),
        .i_addr  (i_if_addr),
        .o_ready (o_if_ready),
        .o_line  (o_if_line),
        .o_done  (o_if_done),
        .rd      (if_rd.engine)
    );

    dline_mover dline_mover_i (
        .i_clk   (i_clk),
        .i_rst   (i_rst),
        .i_valid (i_dl_valid),
        .i_write (i_dl_write),
        .i_addr  (i_dl_addr),
        .i_wline (i_dl_wline),
        .o_ready (o_dl_ready),
        .o_rline (o_dl_rline),
        .o_done  (o_dl_done),
        .rd      (dl_rd.engine),
        .wr      (dl_wr.engine)
    );

    // axi ports match by name
    axi_port_arbiter axi_port_arbiter_i (
        .irq_rd (if_rd.arbiter),
        .drq_rd (dl_rd.arbiter),
        .drq_wr (dl_wr.arbiter),
        .*
    );

endmodule

// File: logic/mem_bridge_pkg.sv
package mem_bridge_pkg;

    // cache line geometry
    localparam int LINE_WORDS = 4;

    // axi len field is beats minus one
    localparam logic [3:0] BURST_LEN = 4'(LINE_WORDS - 1);

    // 4 bytes per beat
    localparam logic [2:0] WORD_SIZE = 3'b010;

    // incrementing burst code
    localparam logic [1:0] BURST_INCR = 2'b01;

    // bit 0 of the id steers read data back to its engine
    localparam logic [3:0] ID_IFETCH = 4'd0;
    localparam logic [3:0] ID_DATA = 4'd1;

    // word 0 sits in the low 32 bits
    typedef logic [LINE_WORDS-1:0][31:0] line_t;

    // one address word, seen raw on the bus or split into fields
    typedef union packed {
        logic [31:0] raw;
        struct packed {
            // line number
            logic [27:0] line;
            // word inside the line
            logic [1:0] word;
            // byte inside the word
            logic [1:0] byte_off;
        } f;
    } addr_u;

endpackage

// File: logic/rd_bus_if.sv
`timescale 1ns/1ps

interface rd_bus_if;

    // request side, one line per request
    logic [31:0] req_addr;
    logic        req_valid;
    logic        req_ready;

    // data beats back to the engine
    logic [31:0] rdata;
    logic        rlast;
    logic        rvalid;
    logic        rready;

    modport engine (
        output req_addr,
        output req_valid,
        output rready,
        input  req_ready,
        input  rdata,
        input  rlast,
        input  rvalid
    );

    modport arbiter (
        input  req_addr,
        input  req_valid,
        input  rready,
        output req_ready,
        output rdata,
        output rlast,
        output rvalid
    );

endinterface

// File: logic/wr_bus_if.sv
`timescale 1ns/1ps

interface wr_bus_if;

    // write address
    logic [31:0] awaddr;
    logic        awvalid;
    logic        awready;

    // write data beats
    logic [31:0] wdata;
    logic        wlast;
    logic        wvalid;
    logic        wready;

    // write response
    logic        bvalid;
    logic        bready;

    modport engine (
        output awaddr,
        output awvalid,
        output wdata,
        output wlast,
        output wvalid,
        output bready,
        input  awready,
        input  wready,
        input  bvalid
    );

    modport arbiter (
        input  awaddr,
        input  awvalid,
        input  wdata,
        input  wlast,
        input  wvalid,
        input  bready,
        output awready,
        output wready,
        output bvalid
    );

endinterface

// File: mem_bridge.f
logic/mem_bridge_pkg.sv
logic/rd_bus_if.sv
logic/wr_bus_if.sv
logic/ifetch_refill.sv
logic/dline_mover.sv
logic/axi_port_arbiter.sv
logic/mem_bridge.sv
dv/axi_mem_model.sv
dv/mem_bridge_chk.sv
dv/mem_bridge_tb.sv
